/* flist.f */
+incdir+.
rvIsaPkg.sv
fetchPkg.sv
instructionMemory.sv
fetchUnit.sv
fetchQueue.sv
instrDecoder.sv
fetchTop.sv
tbClock.sv
fetchTb.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

# build the testbench with the design
verilator --binary --timing -Wno-fatal --top-module fetchTb -f flist.f \
    -Mdir obj_dir -o fetchSim

# a failing run exits nonzero, the log search below decides
./obj_dir/fetchSim > sim.log 2>&1 || true
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
if ! grep -q "PASS: all tests" sim.log; then
    echo "simulation ended without a pass line"
    exit 1
fi

/* fetch_golden.txt */
# P addr word         program word at a byte address, both hex
# E pc class rd imm   expected record, pc and imm hex, class (opClassT order) and rd decimal
P 00000000 00500093 addi x1, x0, 5
P 00000004 022081B3 mul x3, x1, x2
P 00000008 0220C233 div x4, x1, x2
P 0000000C 00312423 sw x3, 8(x2)
P 00000010 FFC12283 lw x5, -4(x2)
P 00000014 00208333 add x6, x1, x2
P 00000018 00C000EF jal x1, +12
P 0000001C 00100393 wrong path
P 00000020 FFFFFFFF wrong path
P 00000024 300093F3 csrrw x7, mstatus, x1
P 00000028 30200073 mret
P 0000002C 0000000B unknown opcode
P 00000030 12345437 lui x8, 0x12345
P 00000034 FE000CE3 beq x0, x0, -8
P 00000038 00001497 auipc x9, 1
P 0000003C 00008067 jalr x0, 0(x1)
E 00000000 1 1 00000005
E 00000004 2 3 00000000
E 00000008 2 4 00000000
E 0000000C 4 0 00000008
E 00000010 3 5 FFFFFFFC
E 00000014 0 6 00000000
E 00000018 6 1 0000000C
E 00000024 10 7 00000300
E 00000028 11 0 00000302
E 0000002C 12 0 00000000
E 00000030 8 8 12345000
E 00000034 5 0 FFFFFFF8
E 00000038 9 9 00001000
E 0000003C 7 0 00000000

/* fetchTb.sv */
`timescale 1ns/1ns
`include "fetch_params.svh"

module fetchTb;

    logic                   clk;
    logic                   arstN;
    logic                   loadEn;
    logic [31:0]            loadAddr;
    logic [7:0]             loadData;
    logic                   decodeReady;
    logic                   loadDone;
    logic                   goldenRead;
    rvIsaPkg::decodedInstrT decoded;
    logic                   decodedValid;

    // program image and expected stream from the golden file
    logic [31:0]            progAddr [$];
    logic [31:0]            progWord [$];
    rvIsaPkg::decodedInstrT expected [$];

    int seed = 32'h0c5b_1c10;
    int recIdx = 0;
    int errorCount = 0;

    tbClock clockGen0 (
        .loadDone(loadDone), .clk(clk), .arstN(arstN)
    );

    fetchTop dut0 (
        .clk(clk), .arstN(arstN), .loadEn(loadEn), .loadAddr(loadAddr),
        .loadData(loadData), .decodeReady(decodeReady), .decoded(decoded),
        .decodedValid(decodedValid)
    );

    task automatic abortRun(string why);
        $display("Error at %0t ns: %s", $time, why);
        $display("FAIL: see errors above");
        $fatal(1, "run aborted");
    endtask

    task automatic checkValue(string what, logic [31:0] got, logic [31:0] want);
        if (got !== want) begin
            $display("Fail at %0t ns: record %0d %s is %h, expected %h",
                     $time, recIdx, what, got, want);
            errorCount++;
        end
    endtask

    task automatic finishRun();
        if (errorCount == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            $display("FAIL: see errors above");
            $fatal(1, "decoded record mismatch");
        end
    endtask

    // P lines fill the image
    // E lines give the expected records
    task automatic readGolden();
        int                     fd;
        int                     cls;
        int                     rd;
        logic [31:0]            addr;
        logic [31:0]            word;
        logic [31:0]            imm;
        string                  line;
        rvIsaPkg::decodedInstrT rec;
        fd = $fopen("fetch_golden.txt", "r");
        if (fd == 0) begin
            abortRun("cannot open fetch_golden.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if ($sscanf(line, "P %h %h", addr, word) == 2) begin
                    // whole word must sit inside the memory
                    if (addr + 32'd3 >= `IMEM_BYTES) begin
                        abortRun("program word lies outside the instruction memory");
                    end else begin
                        progAddr.push_back(addr);
                        progWord.push_back(word);
                    end
                end else if ($sscanf(line, "E %h %d %d %h", addr, cls, rd, imm) == 4) begin
                    rec         = '0;
                    rec.pc      = addr;
                    rec.opClass = rvIsaPkg::opClassT'(cls);
                    rec.rd      = 5'(rd);
                    rec.imm     = imm;
                    expected.push_back(rec);
                end
            end
            $fclose(fd);
            if (expected.size() == 0) begin
                abortRun("golden file holds no expected records");
            end else if (expected[0].pc != `RESET_PC) begin
                abortRun("expected stream does not start at the reset pc");
            end
        end
    endtask

    // image goes in byte by byte while reset holds
    initial begin
        loadEn      = 1'b0;
        loadAddr    = '0;
        loadData    = '0;
        decodeReady = 1'b0;
        loadDone    = 1'b0;
        goldenRead  = 1'b0;
        readGolden();
        goldenRead = 1'b1;
        for (int w = 0; w < progAddr.size(); w++) begin
            // most significant byte goes to the lowest address
            for (int b = 0; b < 4; b++) begin
                @(posedge clk);
                loadEn   <= 1'b1;
                loadAddr <= progAddr[w] + 32'(b);
                loadData <= 8'(progWord[w] >> (24 - 8 * b));
            end
        end
        @(posedge clk);
        loadEn   <= 1'b0;
        loadDone <= 1'b1;
        wait (arstN === 1'b1);
        forever begin
            @(posedge clk);
            // ready about three cycles in four
            decodeReady <= (($random(seed) & 32'h3) != 0);
        end
    end

    // sample at the falling edge where outputs are stable
    // delivery happens at the following rising edge
    always @(negedge clk) begin
        if (arstN && decodedValid && decodeReady) begin
            checkValue("pc", decoded.pc, expected[recIdx].pc);
            checkValue("opClass", 32'(decoded.opClass), 32'(expected[recIdx].opClass));
            checkValue("rd", 32'(decoded.rd), 32'(expected[recIdx].rd));
            checkValue("imm", decoded.imm, expected[recIdx].imm);
            recIdx++;
            if (errorCount != 0 || recIdx == expected.size()) begin
                finishRun();
            end
        end
    end

    // load time, reset and 40 cycles per record
    initial begin
        int limit;
        wait (goldenRead);
        limit = 4 * progAddr.size() + 20 + 40 * expected.size();
        repeat (limit) @(posedge clk);
        abortRun($sformatf("decoded stream stopped after %0d of %0d records",
                           recIdx, expected.size()));
    end

endmodule

/* tbClock.sv */
`timescale 1ns/1ns

module tbClock (
    input  logic loadDone,
    output logic clk,
    output logic arstN
);

    localparam int halfPeriod  = 2;
    localparam int resetCycles = 10;

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #halfPeriod clk = ~clk;
    end

    // reset covers the image load, then 10 more cycles
    initial begin
        arstN = 1'b0;
        wait (loadDone);
        repeat (resetCycles) @(posedge clk);
        arstN <= 1'b1;
    end

endmodule

/* fetchTop.sv */
`timescale 1ns/1ns

module fetchTop (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic                   loadEn,
    input  logic [31:0]            loadAddr,
    input  logic [7:0]             loadData,
    input  logic                   decodeReady,
    output rvIsaPkg::decodedInstrT decoded,
    output logic                   decodedValid
);

    logic [31:0]           fetchPc;
    logic [31:0]           fetchInstr;
    logic                  push;
    logic                  pop;
    logic                  flush;
    logic                  full;
    logic                  notEmpty;
    fetchPkg::fetchBundleT pushBundle;
    fetchPkg::fetchBundleT headBundle;
    fetchPkg::redirectT    redirect;

    // image loads through the byte port while reset is held
    instructionMemory imem0 (
        .clk(clk), .loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData),
        .fetchPc(fetchPc), .fetchInstr(fetchInstr)
    );

    fetchUnit fetch0 (
        .clk(clk), .arstN(arstN), .full(full), .redirect(redirect),
        .fetchPc(fetchPc), .fetchInstr(fetchInstr), .push(push), .pushBundle(pushBundle)
    );

    fetchQueue queue0 (
        .clk(clk), .arstN(arstN), .push(push), .pushBundle(pushBundle), .pop(pop),
        .flush(flush), .full(full), .notEmpty(notEmpty), .headBundle(headBundle)
    );

    // jal redirect loops back to fetch and queue
    instrDecoder decode0 (
        .headBundle(headBundle), .notEmpty(notEmpty), .decodeReady(decodeReady),
        .pop(pop), .flush(flush), .redirect(redirect), .decoded(decoded),
        .decodedValid(decodedValid)
    );

endmodule

/* instrDecoder.sv */
`timescale 1ns/1ns

module instrDecoder (
    input  fetchPkg::fetchBundleT  headBundle,
    input  logic                   notEmpty,
    input  logic                   decodeReady,
    output logic                   pop,
    output logic                   flush,
    output fetchPkg::redirectT     redirect,
    output rvIsaPkg::decodedInstrT decoded,
    output logic                   decodedValid
);

    logic [31:0] instr;
    logic [6:0]  opcode;
    logic [6:0]  funct7;
    logic [31:0] immI;
    logic [31:0] immS;
    logic [31:0] immB;
    logic [31:0] immU;
    logic [31:0] immJ;
    logic        hasRd;

    assign instr  = headBundle.instr;
    assign opcode = instr[6:0];
    assign funct7 = instr[31:25];

    // immediates per format, sign bit is always instr[31]
    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign immU = {instr[31:12], 12'b0};
    assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        decoded.pc     = headBundle.pc;
        decoded.rs1    = instr[19:15];
        decoded.rs2    = instr[24:20];
        decoded.funct3 = instr[14:12];
        decoded.imm    = 32'd0;
        hasRd          = 1'b1;
        case (opcode)
            rvIsaPkg::OPCODE_OP: begin
                // funct7 splits M extension from base alu ops
                if (funct7 == rvIsaPkg::FUNCT7_MULDIV) begin
                    decoded.opClass = rvIsaPkg::CLS_MULDIV;
                end else begin
                    decoded.opClass = rvIsaPkg::CLS_OP;
                end
            end
            rvIsaPkg::OPCODE_OP_IMM: begin
                decoded.opClass = rvIsaPkg::CLS_OP_IMM;
                decoded.imm     = immI;
            end
            rvIsaPkg::OPCODE_LOAD: begin
                decoded.opClass = rvIsaPkg::CLS_LOAD;
                decoded.imm     = immI;
            end
            rvIsaPkg::OPCODE_STORE: begin
                decoded.opClass = rvIsaPkg::CLS_STORE;
                decoded.imm     = immS;
                hasRd           = 1'b0;
            end
            rvIsaPkg::OPCODE_BRANCH: begin
                decoded.opClass = rvIsaPkg::CLS_BRANCH;
                decoded.imm     = immB;
                hasRd           = 1'b0;
            end
            rvIsaPkg::OPCODE_JAL: begin
                decoded.opClass = rvIsaPkg::CLS_JAL;
                decoded.imm     = immJ;
            end
            rvIsaPkg::OPCODE_JALR: begin
                decoded.opClass = rvIsaPkg::CLS_JALR;
                decoded.imm     = immI;
            end
            rvIsaPkg::OPCODE_LUI: begin
                decoded.opClass = rvIsaPkg::CLS_LUI;
                decoded.imm     = immU;
            end
            rvIsaPkg::OPCODE_AUIPC: begin
                decoded.opClass = rvIsaPkg::CLS_AUIPC;
                decoded.imm     = immU;
            end
            rvIsaPkg::OPCODE_SYSTEM: begin
                decoded.imm = immI;
                // funct3 nonzero is a csr access
                // funct3 zero is only accepted as mret
                if (instr[14:12] != 3'b000) begin
                    decoded.opClass = rvIsaPkg::CLS_CSR;
                end else if (instr[31:20] == rvIsaPkg::IMM_MRET) begin
                    decoded.opClass = rvIsaPkg::CLS_MRET;
                    hasRd           = 1'b0;
                end else begin
                    decoded.opClass = rvIsaPkg::CLS_ILLEGAL;
                    hasRd           = 1'b0;
                end
            end
            default: begin
                decoded.opClass = rvIsaPkg::CLS_ILLEGAL;
                hasRd           = 1'b0;
            end
        endcase
        // stores, branches, mret and illegal words write no register
        decoded.rd = hasRd ? instr[11:7] : 5'd0;
    end

    assign decodedValid = notEmpty;
    assign pop          = notEmpty && decodeReady;

    // jal target needs no register, resolve it here
    assign redirect.valid  = pop && (decoded.opClass == rvIsaPkg::CLS_JAL);
    assign redirect.target = headBundle.pc + immJ;
    // words behind a taken jal are wrong path
    assign flush = redirect.valid;

endmodule

/* fetchQueue.sv */
`timescale 1ns/1ns
`include "fetch_params.svh"

module fetchQueue (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  push,
    input  fetchPkg::fetchBundleT pushBundle,
    input  logic                  pop,
    input  logic                  flush,
    output logic                  full,
    output logic                  notEmpty,
    output fetchPkg::fetchBundleT headBundle
);

    localparam int unsigned depth = `FETCH_QUEUE_DEPTH;
    localparam int unsigned ptrW = $clog2(depth);
    localparam int unsigned countW = $clog2(depth + 1);

    // payload storage, pointers and count hold the state
    fetchPkg::fetchBundleT entries [depth];

    logic [ptrW-1:0]   wrPtr;
    logic [ptrW-1:0]   rdPtr;
    logic [countW-1:0] count;
    logic              doPush;
    logic              doPop;

    assign full     = (count == countW'(depth));
    assign notEmpty = (count != '0);

    // ignore requests that would overflow or underflow
    assign doPush = push && !full;
    assign doPop  = pop && notEmpty;

    always_ff @(posedge clk) begin
        if (doPush && !flush) begin
            entries[wrPtr] <= pushBundle;
        end
    end

    // flush beats push and pop
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else if (flush) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            // pointers wrap naturally at a power-of-two depth
            if (doPush) wrPtr <= wrPtr + 1'b1;
            if (doPop) rdPtr <= rdPtr + 1'b1;
            case ({doPush, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // head is valid only while notEmpty
    assign headBundle = entries[rdPtr];

endmodule

/* fetchUnit.sv */
`timescale 1ns/1ns
`include "fetch_params.svh"

module fetchUnit (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  full,
    input  fetchPkg::redirectT    redirect,
    output logic [31:0]           fetchPc,
    input  logic [31:0]           fetchInstr,
    output logic                  push,
    output fetchPkg::fetchBundleT pushBundle
);

    logic [31:0] pcQ;
    // set one cycle after reset release
    logic        runningQ;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            runningQ <= 1'b0;
        end else begin
            runningQ <= 1'b1;
        end
    end

    // push while running with room in the queue
    // a redirect cycle carries a stale word, so drop it
    assign push = runningQ && !full && !redirect.valid;

    // redirect wins over the sequential step
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pcQ <= `RESET_PC;
        end else if (redirect.valid) begin
            pcQ <= redirect.target;
        end else if (push) begin
            pcQ <= pcQ + 32'd4;
        end
    end

    // pc drives the memory directly
    assign fetchPc = pcQ;

    // bundle pairs the pc with the word read at it
    always_comb begin
        pushBundle.pc    = pcQ;
        pushBundle.instr = fetchInstr;
    end

endmodule

/* instructionMemory.sv */
`timescale 1ns/1ns
`include "fetch_params.svh"

module instructionMemory (
    input  logic        clk,
    input  logic        loadEn,
    input  logic [31:0] loadAddr,
    input  logic [7:0]  loadData,
    input  logic [31:0] fetchPc,
    output logic [31:0] fetchInstr
);

    localparam int unsigned memBytes = `IMEM_BYTES;
    localparam int unsigned addrW = $clog2(memBytes);

    // byte wide program storage
    logic [7:0] mem [memBytes];

    logic [addrW-1:0] loadIdx;
    logic [addrW-1:0] readIdx [4];

    // load port address wraps like the fetch side
    assign loadIdx = addrW'(loadAddr % memBytes);

    always_ff @(posedge clk) begin
        if (loadEn) begin
            mem[loadIdx] <= loadData;
        end
    end

    // four consecutive byte addresses
    // wrap at the top of memory
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            readIdx[i] = addrW'((fetchPc + 32'(i)) % memBytes);
        end
    end

    // byte at pc lands in the top of the word
    assign fetchInstr = {mem[readIdx[0]], mem[readIdx[1]],
                         mem[readIdx[2]], mem[readIdx[3]]};

endmodule

/* fetchPkg.sv */
package fetchPkg;

    // fetched word paired with its address
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] instr;
    } fetchBundleT;

    // control transfer request back into fetch
    // valid for a single cycle
    typedef struct packed {
        logic        valid;
        logic [31:0] target;
    } redirectT;

endpackage

/* rvIsaPkg.sv */
package rvIsaPkg;

    // rv32 major opcodes, bits [6:0]
    localparam logic [6:0] OPCODE_LOAD   = 7'b0000011;
    localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPCODE_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPCODE_STORE  = 7'b0100011;
    localparam logic [6:0] OPCODE_OP     = 7'b0110011;
    localparam logic [6:0] OPCODE_LUI    = 7'b0110111;
    localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;
    localparam logic [6:0] OPCODE_JALR   = 7'b1100111;
    localparam logic [6:0] OPCODE_JAL    = 7'b1101111;
    localparam logic [6:0] OPCODE_SYSTEM = 7'b1110011;

    // funct7 of the M extension under OP
    localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;
    // immediate field that marks mret under SYSTEM with funct3 zero
    localparam logic [11:0] IMM_MRET = 12'h302;

    // instruction class seen by later stages
    typedef enum logic [3:0] {
        CLS_OP,
        CLS_OP_IMM,
        CLS_MULDIV,
        CLS_LOAD,
        CLS_STORE,
        CLS_BRANCH,
        CLS_JAL,
        CLS_JALR,
        CLS_LUI,
        CLS_AUIPC,
        CLS_CSR,
        CLS_MRET,
        CLS_ILLEGAL
    } opClassT;

    // one decoded record, 86 bits
    typedef struct packed {
        logic [31:0] pc;
        opClassT     opClass;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  funct3;
        logic [31:0] imm;
    } decodedInstrT;

endpackage

/* fetch_params.svh */
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// instruction memory size in bytes
// addresses wrap modulo this size
`define IMEM_BYTES 1024

// fetch queue entries, keep a power of two
`define FETCH_QUEUE_DEPTH 4

// program counter after reset
`define RESET_PC 32'h0000_0000

`endif
